// ==== include/exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define XLEN 64

// alu operation codes
`define ALU_ADD      5'd0
`define ALU_SUB      5'd1
`define ALU_MUL      5'd2
`define ALU_SLL      5'd3
`define ALU_SRL      5'd4
`define ALU_SRA      5'd5
`define ALU_SLT      5'd6
`define ALU_SLTU     5'd7
`define ALU_XOR      5'd8
`define ALU_OR       5'd9
`define ALU_AND      5'd10
`define ALU_RETURN_B 5'd11
`define ALU_DIV      5'd12
`define ALU_DIVU     5'd13
`define ALU_REM      5'd14
`define ALU_REMU     5'd15
`define ALU_NONE     5'd31

`define WB_ALU  2'd0
`define WB_LINK 2'd1 // pc + 4
`define WB_WORD 2'd2 // low word, sign extended

`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_OP32    7'b0111011
`define OPC_OPIMM32 7'b0011011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

`endif

// ==== hdl/rvTypes.sv ====
package rvTypes;

    // register-register layout, also used for the funct fields of every format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    // immediate bits are scattered over these three slices
    typedef struct packed {
        logic [11:0] upper;  // inst[31:20]
        logic [7:0]  middle; // inst[19:12]
        logic [4:0]  low;    // inst[11:7]
        logic [6:0]  opcode;
    } immFields_t;

    typedef union packed {
        rType_t     rType;
        immFields_t immView;
    } instWord_u;

endpackage

// ==== hdl/instDecoder.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module instDecoder import rvTypes::*; (
    input  instWord_u   inst,
    output logic [4:0]  aluOp,
    output logic        selA,
    output logic        selB,
    output logic [1:0]  wbSel,
    output logic        isJump,
    output logic        jumpReg,
    output logic        isBranch,
    output logic [2:0]  branchFunct,
    output logic        shamtWord,
    output logic        writeRd,
    output logic        memRead,
    output logic [3:0]  loadBytes,
    output logic        loadSigned,
    output logic [7:0]  memWriteMask,
    output logic        illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst.rType.opcode;
    assign funct3 = inst.rType.funct3;
    assign funct7 = inst.rType.funct7;

    // M extension subset, mulh variants come back as none
    function automatic logic [4:0] mulDivOp(input logic [2:0] f3);
        case (f3)
            3'd0:    return `ALU_MUL;
            3'd4:    return `ALU_DIV;
            3'd5:    return `ALU_DIVU;
            3'd6:    return `ALU_REM;
            3'd7:    return `ALU_REMU;
            default: return `ALU_NONE;
        endcase
    endfunction

    always_comb begin
        aluOp        = `ALU_NONE;
        selA         = 1'b1;
        selB         = 1'b1;
        wbSel        = `WB_ALU;
        isJump       = 1'b0;
        jumpReg      = 1'b0;
        isBranch     = 1'b0;
        branchFunct  = funct3;
        shamtWord    = 1'b0;
        writeRd      = 1'b0;
        memRead      = 1'b0;
        loadBytes    = 4'h0;
        loadSigned   = 1'b0;
        memWriteMask = 8'h00;
        illegal      = 1'b0;

        case (opcode)
            `OPC_OP: begin
                writeRd = 1'b1;
                case (funct7)
                    7'h00: begin
                        case (funct3)
                            3'd0:    aluOp = `ALU_ADD;
                            3'd1:    aluOp = `ALU_SLL;
                            3'd2:    aluOp = `ALU_SLT;
                            3'd3:    aluOp = `ALU_SLTU;
                            3'd4:    aluOp = `ALU_XOR;
                            3'd5:    aluOp = `ALU_SRL;
                            3'd6:    aluOp = `ALU_OR;
                            default: aluOp = `ALU_AND;
                        endcase
                    end
                    7'h20: begin
                        case (funct3)
                            3'd0:    aluOp = `ALU_SUB;
                            3'd5:    aluOp = `ALU_SRA;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h01: begin
                        aluOp = mulDivOp(funct3);
                        illegal = (aluOp == `ALU_NONE);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_OPIMM: begin
                selB = 1'b0;
                writeRd = 1'b1;
                case (funct3)
                    3'd0: aluOp = `ALU_ADD;
                    3'd1: begin
                        aluOp = `ALU_SLL;
                        illegal = (funct7[6:1] != 6'h00); // shamt is 6 bits on rv64
                    end
                    3'd2: aluOp = `ALU_SLT;
                    3'd3: aluOp = `ALU_SLTU;
                    3'd4: aluOp = `ALU_XOR;
                    3'd5: begin
                        case (funct7[6:1])
                            6'h00:   aluOp = `ALU_SRL;
                            6'h10:   aluOp = `ALU_SRA;
                            default: illegal = 1'b1;
                        endcase
                    end
                    3'd6:    aluOp = `ALU_OR;
                    default: aluOp = `ALU_AND;
                endcase
            end
            `OPC_OP32: begin
                writeRd = 1'b1;
                shamtWord = 1'b1;
                wbSel = `WB_WORD;
                case (funct7)
                    7'h00: begin
                        case (funct3)
                            3'd0:    aluOp = `ALU_ADD;
                            3'd1:    aluOp = `ALU_SLL;
                            3'd5:    aluOp = `ALU_SRL;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h20: begin
                        case (funct3)
                            3'd0:    aluOp = `ALU_SUB;
                            3'd5:    aluOp = `ALU_SRA;
                            default: illegal = 1'b1;
                        endcase
                    end
                    7'h01: begin
                        aluOp = mulDivOp(funct3);
                        illegal = (aluOp == `ALU_NONE);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_OPIMM32: begin
                selB = 1'b0;
                writeRd = 1'b1;
                shamtWord = 1'b1;
                wbSel = `WB_WORD;
                case (funct3)
                    3'd0: aluOp = `ALU_ADD;
                    3'd1: begin
                        aluOp = `ALU_SLL;
                        illegal = (funct7 != 7'h00);
                    end
                    3'd5: begin
                        case (funct7)
                            7'h00:   aluOp = `ALU_SRL;
                            7'h20:   aluOp = `ALU_SRA;
                            default: illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_LOAD: begin
                selB = 1'b0; // address is rs1 + imm
                aluOp = `ALU_ADD;
                writeRd = 1'b1;
                memRead = 1'b1;
                loadBytes = 4'h1 << funct3[1:0];
                loadSigned = ~funct3[2];
                illegal = (funct3 == 3'd7); // no ldu
            end
            `OPC_STORE: begin
                selB = 1'b0;
                aluOp = `ALU_ADD;
                case (funct3)
                    3'd0:    memWriteMask = 8'h01;
                    3'd1:    memWriteMask = 8'h03;
                    3'd2:    memWriteMask = 8'h0F;
                    3'd3:    memWriteMask = 8'hFF;
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_BRANCH: begin
                isBranch = 1'b1;
                illegal = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            `OPC_JAL: begin
                isJump = 1'b1;
                writeRd = 1'b1;
                wbSel = `WB_LINK;
            end
            `OPC_JALR: begin
                isJump = 1'b1;
                jumpReg = 1'b1;
                writeRd = 1'b1;
                wbSel = `WB_LINK;
                illegal = (funct3 != 3'd0);
            end
            `OPC_LUI: begin
                selB = 1'b0;
                aluOp = `ALU_RETURN_B;
                writeRd = 1'b1;
            end
            `OPC_AUIPC: begin
                selA = 1'b0; // pc + imm
                selB = 1'b0;
                aluOp = `ALU_ADD;
                writeRd = 1'b1;
            end
            default: illegal = 1'b1;
        endcase

        // nothing may reach the register file or memory
        if (illegal) begin
            writeRd = 1'b0;
            memRead = 1'b0;
            memWriteMask = 8'h00;
        end
    end

endmodule

// ==== hdl/immGen.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module immGen import rvTypes::*; (
    input  instWord_u         inst,
    output logic [`XLEN-1:0]  imm
);

    logic [11:0] upper;
    logic [7:0]  middle;
    logic [4:0]  low;
    logic        sign;

    assign upper  = inst.immView.upper;
    assign middle = inst.immView.middle;
    assign low    = inst.immView.low;
    assign sign   = upper[11]; // inst[31] in every format

    always_comb begin
        case (inst.immView.opcode)
            `OPC_OPIMM, `OPC_OPIMM32, `OPC_LOAD, `OPC_JALR: begin
                imm = {{(`XLEN-12){sign}}, upper};
            end
            `OPC_STORE: begin
                imm = {{(`XLEN-12){sign}}, upper[11:5], low};
            end
            `OPC_BRANCH: begin
                imm = {{(`XLEN-13){sign}}, sign, low[0], upper[10:5], low[4:1], 1'b0};
            end
            `OPC_LUI, `OPC_AUIPC: begin
                imm = {{(`XLEN-32){sign}}, upper, middle, 12'h000};
            end
            `OPC_JAL: begin
                imm = {{(`XLEN-21){sign}}, sign, middle, upper[0], upper[10:1], 1'b0};
            end
            default: imm = '0; // r-type, no immediate
        endcase
    end

endmodule

// ==== hdl/execUnit.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module execUnit (
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  rs1Val,
    input  logic [`XLEN-1:0]  rs2Val,
    input  logic [`XLEN-1:0]  imm,
    input  logic [4:0]        aluOp,
    input  logic              selA,
    input  logic              selB,
    input  logic [1:0]        wbSel,
    input  logic              isJump,
    input  logic              jumpReg,
    input  logic              isBranch,
    input  logic [2:0]        branchFunct,
    input  logic              shamtWord,
    output logic [`XLEN-1:0]  result,
    output logic [`XLEN-1:0]  nextPc
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [5:0]       shamt;
    logic             signedOp;
    logic             divZero;
    logic             divOvf;
    logic [`XLEN-1:0] quotS;
    logic [`XLEN-1:0] remS;
    logic [`XLEN-1:0] aluRes;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] jalrSum;
    logic             taken;

    assign opA = selA ? rs1Val : pc;
    assign opB = selB ? rs2Val : imm;

    // word forms work on the low half, extended per signedness of the op
    assign signedOp = (aluOp == `ALU_SRA) || (aluOp == `ALU_DIV) || (aluOp == `ALU_REM);

    always_comb begin
        if (!shamtWord) begin
            srcA = opA;
            srcB = opB;
        end else if (signedOp) begin
            srcA = {{(`XLEN-32){opA[31]}}, opA[31:0]};
            srcB = {{(`XLEN-32){opB[31]}}, opB[31:0]};
        end else begin
            srcA = {{(`XLEN-32){1'b0}}, opA[31:0]};
            srcB = {{(`XLEN-32){1'b0}}, opB[31:0]};
        end
    end

    assign shamt = shamtWord ? {1'b0, srcB[4:0]} : srcB[5:0];

    assign divZero = (srcB == '0);
    assign divOvf  = (srcA == {1'b1, {(`XLEN-1){1'b0}}}) && (srcB == '1);
    assign quotS   = $signed(srcA) / $signed(srcB);
    assign remS    = $signed(srcA) % $signed(srcB);

    always_comb begin
        case (aluOp)
            `ALU_ADD:      aluRes = srcA + srcB;
            `ALU_SUB:      aluRes = srcA - srcB;
            `ALU_MUL:      aluRes = srcA * srcB; // low half only
            `ALU_SLL:      aluRes = srcA << shamt;
            `ALU_SRL:      aluRes = srcA >> shamt;
            `ALU_SRA:      aluRes = $signed(srcA) >>> shamt;
            `ALU_SLT:      aluRes = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            `ALU_SLTU:     aluRes = {{(`XLEN-1){1'b0}}, srcA < srcB};
            `ALU_XOR:      aluRes = srcA ^ srcB;
            `ALU_OR:       aluRes = srcA | srcB;
            `ALU_AND:      aluRes = srcA & srcB;
            `ALU_RETURN_B: aluRes = srcB;
            `ALU_DIV:      aluRes = divZero ? '1 : (divOvf ? srcA : quotS);
            `ALU_DIVU:     aluRes = divZero ? '1 : srcA / srcB;
            `ALU_REM:      aluRes = divZero ? srcA : (divOvf ? '0 : remS);
            `ALU_REMU:     aluRes = divZero ? srcA : srcA % srcB;
            default:       aluRes = '0;
        endcase
    end

    assign pcPlus4 = pc + 'd4;

    always_comb begin
        case (wbSel)
            `WB_LINK: result = pcPlus4;
            `WB_WORD: result = {{(`XLEN-32){aluRes[31]}}, aluRes[31:0]};
            default:  result = aluRes;
        endcase
    end

    // branch compare always on the raw register values
    always_comb begin
        case (branchFunct)
            3'd0:    taken = (rs1Val == rs2Val);
            3'd1:    taken = (rs1Val != rs2Val);
            3'd4:    taken = ($signed(rs1Val) < $signed(rs2Val));
            3'd5:    taken = ($signed(rs1Val) >= $signed(rs2Val));
            3'd6:    taken = (rs1Val < rs2Val);
            3'd7:    taken = (rs1Val >= rs2Val);
            default: taken = 1'b0;
        endcase
    end

    assign jalrSum = rs1Val + imm;

    always_comb begin
        if (isJump && jumpReg) begin
            nextPc = {jalrSum[`XLEN-1:1], 1'b0};
        end else if (isJump || (isBranch && taken)) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

// ==== hdl/execStage.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module execStage import rvTypes::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instValid,
    input  instWord_u         inst,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  rs1Val,
    input  logic [`XLEN-1:0]  rs2Val,
    output logic              outValid,
    output logic [`XLEN-1:0]  result,
    output logic [`XLEN-1:0]  nextPc,
    output logic              writeRd,
    output logic              memRead,
    output logic [7:0]        memWriteMask,
    output logic [3:0]        loadBytes,
    output logic              loadSigned,
    output logic              illegal
);

    logic [4:0]       aluOp;
    logic             selA;
    logic             selB;
    logic [1:0]       wbSel;
    logic             isJump;
    logic             jumpReg;
    logic             isBranch;
    logic [2:0]       branchFunct;
    logic             shamtWord;
    logic             decWriteRd;
    logic             decMemRead;
    logic [3:0]       decLoadBytes;
    logic             decLoadSigned;
    logic [7:0]       decWriteMask;
    logic             decIllegal;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] exResult;
    logic [`XLEN-1:0] exNextPc;

    instDecoder uDecoder (
        .inst         (inst),
        .aluOp        (aluOp),
        .selA         (selA),
        .selB         (selB),
        .wbSel        (wbSel),
        .isJump       (isJump),
        .jumpReg      (jumpReg),
        .isBranch     (isBranch),
        .branchFunct  (branchFunct),
        .shamtWord    (shamtWord),
        .writeRd      (decWriteRd),
        .memRead      (decMemRead),
        .loadBytes    (decLoadBytes),
        .loadSigned   (decLoadSigned),
        .memWriteMask (decWriteMask),
        .illegal      (decIllegal)
    );

    immGen uImmGen (
        .inst (inst),
        .imm  (imm)
    );

    execUnit uExec (
        .pc          (pc),
        .rs1Val      (rs1Val),
        .rs2Val      (rs2Val),
        .imm         (imm),
        .aluOp       (aluOp),
        .selA        (selA),
        .selB        (selB),
        .wbSel       (wbSel),
        .isJump      (isJump),
        .jumpReg     (jumpReg),
        .isBranch    (isBranch),
        .branchFunct (branchFunct),
        .shamtWord   (shamtWord),
        .result      (exResult),
        .nextPc      (exNextPc)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid     <= 1'b0;
            writeRd      <= 1'b0;
            memRead      <= 1'b0;
            memWriteMask <= 8'h00;
            illegal      <= 1'b0;
        end else begin
            outValid <= instValid; // single pulse per strobe
            if (instValid) begin
                writeRd      <= decWriteRd;
                memRead      <= decMemRead;
                memWriteMask <= decWriteMask;
                illegal      <= decIllegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instValid) begin
            result     <= exResult;
            nextPc     <= exNextPc;
            loadBytes  <= decLoadBytes;
            loadSigned <= decLoadSigned;
        end
    end

endmodule

// ==== sim/execStage_tb.sv ====
`timescale 1ns/1ps
`include "exec_params.svh"

module execStage_tb import rvTypes::*; ();

    localparam string TEST_FILE = "sim/exec_tests.txt";
    localparam int    CLK_PERIOD = 8;

    logic             clk;
    logic             rstN;
    logic             instValid;
    instWord_u        inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic             outValid;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] nextPc;
    logic             writeRd;
    logic             memRead;
    logic [7:0]       memWriteMask;
    logic [3:0]       loadBytes;
    logic             loadSigned;
    logic             illegal;

    string testLines[$];
    bit    testsLoaded = 1'b0;

    execStage u_dut (
        .clk          (clk),
        .rstN         (rstN),
        .instValid    (instValid),
        .inst         (inst),
        .pc           (pc),
        .rs1Val       (rs1Val),
        .rs2Val       (rs2Val),
        .outValid     (outValid),
        .result       (result),
        .nextPc       (nextPc),
        .writeRd      (writeRd),
        .memRead      (memRead),
        .memWriteMask (memWriteMask),
        .loadBytes    (loadBytes),
        .loadSigned   (loadSigned),
        .illegal      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                             input string what);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkMask(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // budget grows with the number of test lines
    initial begin
        wait (testsLoaded);
        repeat (testLines.size() * 6 + 20) @(posedge clk);
        abortRun("timeout: the tests did not complete in the expected number of cycles");
    end

    initial begin
        int               fd;
        int               fields;
        int               idle;
        string            line;
        string            tag;
        logic [31:0]      instBits;
        logic [`XLEN-1:0] pcIn;
        logic [`XLEN-1:0] rs1In;
        logic [`XLEN-1:0] rs2In;
        logic [`XLEN-1:0] expResult;
        logic [`XLEN-1:0] expNextPc;
        logic             expWriteRd;
        logic             expMemRead;
        logic [7:0]       expMask;
        logic [3:0]       expLoadBytes;
        logic             expLoadSigned;
        logic             expIllegal;

        void'($urandom(503));
        rstN      = 1'b0;
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        rs1Val    = '0;
        rs2Val    = '0;

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abortRun("cannot open the test data file sim/exec_tests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin // skip comments and blanks
                testLines.push_back(line);
            end
        end
        $fclose(fd);
        testsLoaded = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkFlag(outValid, 1'b0, "outValid after reset");
        checkFlag(writeRd, 1'b0, "writeRd after reset");
        checkFlag(memRead, 1'b0, "memRead after reset");
        checkMask(memWriteMask, 8'h00, "memWriteMask after reset");
        checkFlag(illegal, 1'b0, "illegal after reset");

        for (int i = 0; i < testLines.size(); i++) begin
            fields = $sscanf(testLines[i], "%h %h %h %h %h %h %h %h %h %h %h %h",
                             instBits, pcIn, rs1In, rs2In, expResult, expNextPc,
                             expWriteRd, expMemRead, expMask, expLoadBytes,
                             expLoadSigned, expIllegal);
            if (fields != 12) begin
                abortRun($sformatf("test line %0d of the data file is malformed", i + 1));
            end
            inst      = instBits;
            pc        = pcIn;
            rs1Val    = rs1In;
            rs2Val    = rs2In;
            instValid = 1'b1;
            @(negedge clk);
            instValid = 1'b0;
            if (outValid !== 1'b1) begin
                abortRun($sformatf("test %0d: outValid did not rise one cycle after the strobe",
                                   i + 1));
            end
            tag = $sformatf("test %0d (inst %h)", i + 1, instBits);
            checkWord(result, expResult, {tag, " result"});
            checkWord(nextPc, expNextPc, {tag, " nextPc"});
            checkFlag(writeRd, expWriteRd, {tag, " writeRd"});
            checkFlag(memRead, expMemRead, {tag, " memRead"});
            checkMask(memWriteMask, expMask, {tag, " memWriteMask"});
            checkMask({4'h0, loadBytes}, {4'h0, expLoadBytes}, {tag, " loadBytes"});
            checkFlag(loadSigned, expLoadSigned, {tag, " loadSigned"});
            checkFlag(illegal, expIllegal, {tag, " illegal"});

            idle = $urandom % 3; // 0 gives back-to-back issue
            repeat (idle) begin
                @(negedge clk);
                checkFlag(outValid, 1'b0, "outValid in an idle cycle");
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
hdl/rvTypes.sv
hdl/instDecoder.sv
hdl/immGen.sv
hdl/execUnit.sv
hdl/execStage.sv
sim/execStage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := execStage_tb
FILELIST  := build.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== sim/exec_tests.txt ====
# inst pc rs1Val rs2Val | result nextPc writeRd memRead memWriteMask loadBytes loadSigned illegal
# all values in hex
002081b3 1000 7fffffffffffffff 1 8000000000000000 1004 1 0 00 0 0 0
402081b3 1000 10 20 fffffffffffffff0 1004 1 0 00 0 0 0
002091b3 1000 1 43 8 1004 1 0 00 0 0 0
0020a1b3 1000 ffffffffffffffff 1 1 1004 1 0 00 0 0 0
0020b1b3 1000 ffffffffffffffff 1 0 1004 1 0 00 0 0 0
0020c1b3 1000 ff00ff00ff00ff00 0ff00ff00ff00ff0 f0f0f0f0f0f0f0f0 1004 1 0 00 0 0 0
4020d1b3 1000 8000000000000000 4 f800000000000000 1004 1 0 00 0 0 0
022081b3 1000 100000000 100000003 300000000 1004 1 0 00 0 0 0
0220d1b3 1000 1234 0 ffffffffffffffff 1004 1 0 00 0 0 0
0220e1b3 1000 fffffffffffffff9 2 ffffffffffffffff 1004 1 0 00 0 0 0
ffb08193 1000 3 0 fffffffffffffffe 1004 1 0 00 0 0 0
02409193 1000 3 0 3000000000 1004 1 0 00 0 0 0
4080d193 1000 8000000000000000 0 ff80000000000000 1004 1 0 00 0 0 0
002081bb 1000 7fffffff 1 ffffffff80000000 1004 1 0 00 0 0 0
402081bb 1000 ffffffff00000000 1 ffffffffffffffff 1004 1 0 00 0 0 0
0040919b 1000 12345678 0 23456780 1004 1 0 00 0 0 0
0040d19b 1000 ffffffff80000000 0 8000000 1004 1 0 00 0 0 0
022081bb 1000 10000 8000 ffffffff80000000 1004 1 0 00 0 0 0
0220c1bb 1000 fffffff8 3 fffffffffffffffe 1004 1 0 00 0 0 0
0220e1bb 1000 fffffff9 4 fffffffffffffffd 1004 1 0 00 0 0 0
0220f1bb 1000 fffffff9 10 9 1004 1 0 00 0 0 0
0220f1bb 1000 80000001 0 ffffffff80000001 1004 1 0 00 0 0 0
800001b7 1000 0 0 ffffffff80000000 1004 1 0 00 0 0 0
00001197 1000 0 0 2000 1004 1 0 00 0 0 0
100001ef 1000 0 0 1004 1100 1 0 00 0 0 0
ff9ff1ef 1000 0 0 1004 ff8 1 0 00 0 0 0
003081e7 1000 2000 0 1004 2002 1 0 00 0 0 0
00208863 400 5 5 0 410 0 0 00 0 0 0
00208863 400 5 6 0 404 0 0 00 0 0 0
00209863 400 5 6 0 410 0 0 00 0 0 0
00209863 400 5 5 0 404 0 0 00 0 0 0
0020c863 400 ffffffffffffffff 1 0 410 0 0 00 0 0 0
0020c863 400 1 ffffffffffffffff 0 404 0 0 00 0 0 0
0020d863 400 1 ffffffffffffffff 0 410 0 0 00 0 0 0
0020d863 400 ffffffffffffffff 1 0 404 0 0 00 0 0 0
0020e863 400 1 ffffffffffffffff 0 410 0 0 00 0 0 0
0020e863 400 ffffffffffffffff 1 0 404 0 0 00 0 0 0
0020f863 400 ffffffffffffffff 1 0 410 0 0 00 0 0 0
0020f863 400 1 ffffffffffffffff 0 404 0 0 00 0 0 0
00808183 1000 2000 0 2008 1004 1 1 00 1 1 0
0080d183 1000 2000 0 2008 1004 1 1 00 2 0 0
ff00b183 1000 1010 0 1000 1004 1 1 00 8 1 0
00208223 1000 3000 ab 3004 1004 0 0 01 0 0 0
00209223 1000 3000 ab 3004 1004 0 0 03 0 0 0
0020a223 1000 3000 ab 3004 1004 0 0 0f 0 0 0
0020b223 1000 3000 ab 3004 1004 0 0 ff 0 0 0
0000007f 1000 5 6 0 1004 0 0 00 0 0 1
402091b3 1000 5 6 0 1004 0 0 00 0 0 1
0020c223 1000 3000 0 3004 1004 0 0 00 0 0 1
0080f183 1000 2000 0 2008 1004 0 0 00 8 0 1
